// File: perf_analyzer.f
+incdir+src
+incdir+testbench
src/perf_pkg.sv
src/stall_classifier.sv
src/stall_counter_bank.sv
src/axil_counter_reader.sv
src/perf_analyzer_top.sv
testbench/tb_perf_analyzer.sv

// File: testbench/tb_perf_model.svh
// ==============================
// Stall monitor reference rules
// ==============================
`ifndef TB_PERF_MODEL_SVH
`define TB_PERF_MODEL_SVH

// Stimulus word generator
function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
endfunction

// Penalty flag as it stands after this cycle
function automatic logic next_penalty(input logic pen, input logic mispred, input rs_status_t st);
    if (mispred)
        return 1'b1;
    if (pen && (st.issue_valid || st.occupied))
        return 1'b0;
    return pen;
endfunction

// Cause code of one station for this cycle
function automatic int expected_cause(input rs_status_t st, input logic pen,
                                      input logic mispred, input issue_stage_t dly, input int rs);
    logic wait_a;
    logic wait_b;
    wait_a = (st.operand_a_tag != `PERF_TAG_READY);
    wait_b = (st.operand_b_tag != `PERF_TAG_READY);
    if (st.issue_valid)
        return 0;
    if (!st.occupied) begin
        if (pen || mispred)
            return 1;
        if (!dly.decode_ready[rs]) begin
            if (dly.lsq_alloc_ready != '1)
                return 2;
            return dly.rename_ready[rs] ? 4 : 3;
        end
        return dly.decode_valid[rs] ? 6 : 5;
    end
    if (wait_a && wait_b)
        return 7;
    if (wait_a)
        return 8;
    return wait_b ? 9 : 10;
endfunction

`endif

// File: testbench/tb_perf_analyzer.sv
// ==============================
// Stall monitor testbench
// ==============================
`timescale 1ns/1ns
`include "perf_defs.svh"

module tb_perf_analyzer
    import perf_pkg::*;
();

    logic         clk;
    logic         reset;
    rs_status_t   rs_status [`PERF_NUM_RS];
    logic         misprediction_detected;
    issue_stage_t issue_stage;
    axil_ar_t     ar;
    logic         arready;
    axil_r_t      r;
    logic         rready;

    // Reference model state
    issue_stage_t            m_dly [`PERF_ALIGN_DEPTH];
    logic [`PERF_NUM_RS-1:0] m_pen;
    logic [31:0]             m_cnt [`PERF_NUM_RS][`PERF_NUM_CAUSE];
    logic [31:0]             m_cycles;
    logic [31:0]             lcg_state;
    int                      errors;
    int                      test_errors;
    int                      tests;

    `include "tb_perf_model.svh"

    perf_analyzer_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ==============================
    // Lockstep model
    // ==============================
    always @(posedge clk) begin : model_step
        int c;
        if (reset) begin
            m_dly    <= '{default: '0};
            m_pen    <= '0;
            m_cnt    <= '{default: '0};
            m_cycles <= '0;
        end else begin
            m_dly[0] <= issue_stage;
            for (int k = 1; k < `PERF_ALIGN_DEPTH; k++) begin
                m_dly[k] <= m_dly[k-1];
            end
            for (int i = 0; i < `PERF_NUM_RS; i++) begin
                c = expected_cause(rs_status[i], m_pen[i], misprediction_detected,
                                   m_dly[`PERF_ALIGN_DEPTH-1], i);
                m_cnt[i][c] <= m_cnt[i][c] + 1;
                m_pen[i]    <= next_penalty(m_pen[i], misprediction_detected, rs_status[i]);
            end
            m_cycles <= m_cycles + 1;
        end
    end

    task automatic note_error(input string test, input string text);
        $display("%s: %s", test, text);
        errors++;
        test_errors++;
    endtask

    task automatic note_mismatch(input string test, input string what,
                                 input logic [31:0] exp, input logic [31:0] act);
        $display("mismatch %s %s: expected %0h, actual %0h", test, what, exp, act);
        errors++;
        test_errors++;
    endtask

    task automatic finish_test(input string test);
        $display("test %s done, %0d errors", test, test_errors);
        tests++;
        test_errors = 0;
    endtask

    // ==============================
    // Stimulus
    // ==============================
    task automatic drive_random();
        logic [31:0] a;
        logic [31:0] b;
        lcg_state = lcg_next(lcg_state);
        // Fold high bits down, low LCG bits repeat quickly
        a = lcg_state ^ (lcg_state >> 16);
        lcg_state = lcg_next(lcg_state);
        b = lcg_state ^ (lcg_state >> 16);
        for (int i = 0; i < `PERF_NUM_RS; i++) begin
            rs_status[i] <= '{occupied: a[8*i], issue_valid: a[8*i+1] & a[8*i+2],
                              operand_a_tag: a[8*i+3] ? `PERF_TAG_READY : b[3*i +: 3],
                              operand_b_tag: a[8*i+4] ? `PERF_TAG_READY : b[3*i+9 +: 3]};
        end
        // Mispredictions stay rare so penalties can drain
        misprediction_detected <= (b[31:27] == 5'd0);
        issue_stage <= '{decode_valid: b[20:18], decode_ready: b[23:21],
                         rename_ready: b[26:24],
                         lsq_alloc_ready: a[31] ? 3'b111 : a[30:28]};
    endtask

    task automatic hold_stations(input logic occ, input logic [2:0] ta, input logic [2:0] tb);
        for (int i = 0; i < `PERF_NUM_RS; i++) begin
            rs_status[i] <= '{occupied: occ, issue_valid: 1'b0,
                              operand_a_tag: ta, operand_b_tag: tb};
        end
        misprediction_detected <= 1'b0;
    endtask

    // ==============================
    // AXI4-Lite reads
    // ==============================

    // Station sits in bits 7 and 6 and cause in bits 5 to 2
    function automatic void expected_read(input logic [31:0] addr, output logic [31:0] data,
                                          output logic [1:0] resp);
        int st;
        int c;
        st   = addr[7:6];
        c    = addr[5:2];
        data = '0;
        resp = `PERF_RESP_SLVERR;
        if (st < `PERF_NUM_RS && c < `PERF_NUM_CAUSE) begin
            data = m_cnt[st][c];
            resp = `PERF_RESP_OKAY;
        end else if (st == `PERF_NUM_RS && c == 0) begin
            data = m_cycles;
            resp = `PERF_RESP_OKAY;
        end
    endfunction

    task automatic read_check(input string name, input logic [31:0] addr, input int hold,
                              output logic [31:0] data);
        logic [31:0] exp_data;
        logic [1:0]  exp_resp;
        int          n;
        data = '0;
        ar     <= '{arvalid: 1'b1, araddr: addr};
        rready <= (hold == 0);
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!arready && n < 50);
        // Model value before this edge matches the snapshot
        expected_read(addr, exp_data, exp_resp);
        ar <= '{arvalid: 1'b0, araddr: '0};
        if (!arready) begin
            note_error(name, "timeout waiting for arready");
            return;
        end
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!r.rvalid && n < 50);
        if (!r.rvalid) begin
            note_error(name, "timeout waiting for rvalid");
            rready <= 1'b1;
            return;
        end
        data = r.rdata;
        if (r.rdata !== exp_data)
            note_mismatch(name, "rdata", exp_data, r.rdata);
        if (r.rresp !== exp_resp)
            note_mismatch(name, "rresp", exp_resp, r.rresp);
        for (int k = 0; k < hold; k++) begin
            @(posedge clk);
            if (!r.rvalid)
                note_error(name, "rvalid dropped while rready was low");
            if (arready)
                note_error(name, "arready rose while a response was pending");
            if (r.rdata !== exp_data)
                note_mismatch(name, "held rdata", exp_data, r.rdata);
            if (r.rresp !== exp_resp)
                note_mismatch(name, "held rresp", exp_resp, r.rresp);
        end
        if (hold > 0) begin
            rready <= 1'b1;
            n = 0;
            do begin
                @(posedge clk);
                n++;
            end while (r.rvalid && n < 50);
            if (r.rvalid)
                note_error(name, "timeout waiting for rvalid to drop");
        end
    endtask

    task automatic read_all(input string name, input int first_cause);
        logic [31:0] d;
        for (int st = 0; st < `PERF_NUM_RS; st++) begin
            for (int c = first_cause; c < `PERF_NUM_CAUSE; c++) begin
                read_check(name, (st << `PERF_RS_LSB) | (c << `PERF_CAUSE_LSB), 0, d);
            end
        end
        read_check(name, `PERF_NUM_RS << `PERF_RS_LSB, 0, d);
    endtask

    // ==============================
    // Test sequence
    // ==============================
    initial begin
        logic [31:0] base;
        logic [31:0] rd;
        lcg_state   = 32'h1bbf_98a2;
        errors      = 0;
        test_errors = 0;
        tests       = 0;
        reset                  <= 1'b1;
        rs_status              <= '{default: '0};
        misprediction_detected <= 1'b0;
        issue_stage            <= '0;
        ar                     <= '0;
        rready                 <= 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);

        if (r.rvalid !== 1'b0)
            note_error("reset", "rvalid high before any read");
        if (arready !== 1'b1)
            note_error("reset", "arready low after reset");
        read_all("reset", 0);
        finish_test("reset");

        repeat (2000) begin
            drive_random();
            @(posedge clk);
        end
        read_all("random", 0);
        finish_test("random");

        // One occupied cycle clears any leftover penalty
        issue_stage <= '1;
        hold_stations(1'b1, `PERF_TAG_READY, `PERF_TAG_READY);
        @(posedge clk);
        read_check("penalty", 32'h04, 0, base);
        hold_stations(1'b0, `PERF_TAG_READY, `PERF_TAG_READY);
        misprediction_detected <= 1'b1;
        @(posedge clk);
        misprediction_detected <= 1'b0;
        repeat (5) @(posedge clk);
        rs_status[0].occupied <= 1'b1;
        @(posedge clk);
        hold_stations(1'b0, `PERF_TAG_READY, `PERF_TAG_READY);
        repeat (4) @(posedge clk);
        read_check("penalty", 32'h04, 0, rd);
        // Pulse cycle plus five empty cycles
        if (rd - base !== 32'd6)
            note_mismatch("penalty", "mispred cycles", 32'd6, rd - base);
        read_check("penalty", 32'h18, 0, rd);
        finish_test("penalty");

        hold_stations(1'b1, 3'd2, 3'd2);
        repeat (3) @(posedge clk);
        hold_stations(1'b1, 3'd2, `PERF_TAG_READY);
        repeat (4) @(posedge clk);
        hold_stations(1'b1, `PERF_TAG_READY, 3'd5);
        repeat (5) @(posedge clk);
        hold_stations(1'b1, `PERF_TAG_READY, `PERF_TAG_READY);
        repeat (6) @(posedge clk);
        read_all("dependency", 7);
        finish_test("dependency");

        read_check("unmapped", 32'h0000_00d4, 0, rd);
        read_check("unmapped", 32'h0000_0030, 0, rd);
        finish_test("unmapped");

        read_check("backpressure", 32'h0000_00c0, 5, rd);
        finish_test("backpressure");

        $display("tests %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: src/perf_analyzer_top.sv
// ==============================
// Stall monitor top
// Classifier, counter bank and AXI4-Lite read port
// ==============================
`timescale 1ns/1ns
`include "perf_defs.svh"

module perf_analyzer_top
    import perf_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  rs_status_t   rs_status [`PERF_NUM_RS],
    input  logic         misprediction_detected,
    input  issue_stage_t issue_stage,
    input  axil_ar_t     ar,
    output logic         arready,
    output axil_r_t      r,
    input  logic         rready
);

    stall_cause_e           cause [`PERF_NUM_RS];
    logic [`PERF_CNT_W-1:0] counts [`PERF_NUM_RS*`PERF_NUM_CAUSE];
    logic [`PERF_CNT_W-1:0] cycle_count;

    // Cause per station, every cycle
    stall_classifier u_classifier (
        .clk                    (clk),
        .reset                  (reset),
        .rs_status              (rs_status),
        .misprediction_detected (misprediction_detected),
        .issue_stage            (issue_stage),
        .cause                  (cause)
    );

    stall_counter_bank u_counter_bank (
        .clk         (clk),
        .reset       (reset),
        .cause       (cause),
        .counts      (counts),
        .cycle_count (cycle_count)
    );

    // Software view of the counters
    axil_counter_reader u_reader (
        .clk         (clk),
        .reset       (reset),
        .ar          (ar),
        .arready     (arready),
        .r           (r),
        .rready      (rready),
        .counts      (counts),
        .cycle_count (cycle_count)
    );

endmodule

// File: src/axil_counter_reader.sv
// ==============================
// AXI4-Lite counter reader
// Decodes station and cause, returns a counter snapshot
// ==============================
`timescale 1ns/1ns
`include "perf_defs.svh"

module axil_counter_reader
    import perf_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  axil_ar_t               ar,
    output logic                   arready,
    output axil_r_t                r,
    input  logic                   rready,
    input  logic [`PERF_CNT_W-1:0] counts [`PERF_NUM_RS*`PERF_NUM_CAUSE],
    input  logic [`PERF_CNT_W-1:0] cycle_count
);

    logic [`PERF_RS_SEL_W-1:0]  rd_station;
    logic [`PERF_CAUSE_W-1:0]   rd_cause;
    logic                       rd_mapped;
    logic [`PERF_CNT_W-1:0]     rd_value;
    logic                       ar_fire;
    logic                       rvalid_q;
    logic [`PERF_AXI_DATA_W-1:0] rdata_q;
    logic [1:0]                 rresp_q;

    // ==============================
    // Address decode
    // ==============================
    assign rd_station = ar.araddr[`PERF_RS_LSB +: `PERF_RS_SEL_W];
    assign rd_cause   = ar.araddr[`PERF_CAUSE_LSB +: `PERF_CAUSE_W];

    always_comb begin
        rd_mapped = 1'b0;
        rd_value  = '0;
        if (rd_station < `PERF_NUM_RS && rd_cause < `PERF_NUM_CAUSE) begin
            rd_mapped = 1'b1;
            rd_value  = counts[rd_station*`PERF_NUM_CAUSE + rd_cause];
        end else if (rd_station == `PERF_NUM_RS && rd_cause == '0) begin
            // Station slot past the last RS holds the cycle counter
            rd_mapped = 1'b1;
            rd_value  = cycle_count;
        end
    end

    // ==============================
    // Handshake and response
    // ==============================

    // One read in flight at a time
    assign arready = !rvalid_q;
    assign ar_fire = ar.arvalid && arready;

    always_ff @(posedge clk) begin
        if (reset) begin
            rvalid_q <= 1'b0;
        end else if (ar_fire) begin
            rvalid_q <= 1'b1;
        end else if (rready) begin
            rvalid_q <= 1'b0;
        end
    end

    // Snapshot taken before this cycle's counter update lands
    always_ff @(posedge clk) begin
        if (ar_fire) begin
            rdata_q <= rd_value;
            rresp_q <= rd_mapped ? `PERF_RESP_OKAY : `PERF_RESP_SLVERR;
        end
    end

    assign r = '{rvalid: rvalid_q, rdata: rdata_q, rresp: rresp_q};

endmodule

// File: src/stall_counter_bank.sv
// ==============================
// Stall counter bank
// One counter per station and cause, plus a cycle counter
// ==============================
`timescale 1ns/1ns
`include "perf_defs.svh"

module stall_counter_bank
    import perf_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  stall_cause_e           cause [`PERF_NUM_RS],
    output logic [`PERF_CNT_W-1:0] counts [`PERF_NUM_RS*`PERF_NUM_CAUSE],
    output logic [`PERF_CNT_W-1:0] cycle_count
);

    // ==============================
    // Cause counters
    // ==============================

    // Flat layout, station major, cause code minor
    always_ff @(posedge clk) begin
        if (reset) begin
            counts <= '{default: '0};
        end else begin
            for (int rs = 0; rs < `PERF_NUM_RS; rs++) begin
                for (int c = 0; c < `PERF_NUM_CAUSE; c++) begin
                    // Exactly one hit per station per cycle
                    if (cause[rs] == stall_cause_e'(c)) begin
                        counts[rs*`PERF_NUM_CAUSE + c] <=
                            counts[rs*`PERF_NUM_CAUSE + c] + 1'b1;
                    end
                end
            end
        end
    end

    // ==============================
    // Cycle counter
    // ==============================
    always_ff @(posedge clk) begin
        if (reset) begin
            cycle_count <= '0;
        end else begin
            cycle_count <= cycle_count + 1'b1;
        end
    end

endmodule

// File: src/stall_classifier.sv
// ==============================
// Stall classifier
// Aligns issue stage signals, tracks mispredict penalty, picks a cause
// ==============================
`timescale 1ns/1ns
`include "perf_defs.svh"

module stall_classifier
    import perf_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  rs_status_t   rs_status [`PERF_NUM_RS],
    input  logic         misprediction_detected,
    input  issue_stage_t issue_stage,
    output stall_cause_e cause [`PERF_NUM_RS]
);

    // ==============================
    // Alignment and penalty state
    // ==============================

    // Issue stage runs ahead of the stations by the decode register stages
    issue_stage_t            align_q [`PERF_ALIGN_DEPTH];
    issue_stage_t            aligned;
    logic [`PERF_NUM_RS-1:0] in_penalty;

    always_ff @(posedge clk) begin
        if (reset) begin
            align_q <= '{default: '0};
        end else begin
            align_q[0] <= issue_stage;
            for (int i = 1; i < `PERF_ALIGN_DEPTH; i++) begin
                align_q[i] <= align_q[i-1];
            end
        end
    end

    assign aligned = align_q[`PERF_ALIGN_DEPTH-1];

    // Penalty ends once the station shows refilled work
    always_ff @(posedge clk) begin
        if (reset) begin
            in_penalty <= '0;
        end else begin
            for (int i = 0; i < `PERF_NUM_RS; i++) begin
                if (misprediction_detected) begin
                    in_penalty[i] <= 1'b1;
                end else if (in_penalty[i] &&
                             (rs_status[i].issue_valid || rs_status[i].occupied)) begin
                    in_penalty[i] <= 1'b0;
                end
            end
        end
    end

    // ==============================
    // Per station classification
    // ==============================
    for (genvar g = 0; g < `PERF_NUM_RS; g++) begin : g_rs
        logic wait_a;
        logic wait_b;

        assign wait_a = (rs_status[g].operand_a_tag != `PERF_TAG_READY);
        assign wait_b = (rs_status[g].operand_b_tag != `PERF_TAG_READY);

        always_comb begin
            if (rs_status[g].issue_valid) begin
                cause[g] = CAUSE_ISSUED;
            end else if (!rs_status[g].occupied) begin
                // Empty station, blame recovery first, then the front end
                if (in_penalty[g] || misprediction_detected) begin
                    cause[g] = CAUSE_MISPRED;
                end else if (!aligned.decode_ready[g]) begin
                    // Decode ready is gated by a full LSQ across all ways
                    if (aligned.lsq_alloc_ready != '1) begin
                        cause[g] = CAUSE_LSQ_FULL;
                    end else if (!aligned.rename_ready[g]) begin
                        cause[g] = CAUSE_ROB_FULL;
                    end else begin
                        cause[g] = CAUSE_DECODE_OTHER;
                    end
                end else if (!aligned.decode_valid[g]) begin
                    cause[g] = CAUSE_BUFFER_EMPTY;
                end else begin
                    cause[g] = CAUSE_PREV_OTHER;
                end
            end else begin
                // Occupied but held back
                case ({wait_a, wait_b})
                    2'b11:   cause[g] = CAUSE_WAIT_BOTH;
                    2'b10:   cause[g] = CAUSE_WAIT_A;
                    2'b01:   cause[g] = CAUSE_WAIT_B;
                    default: cause[g] = CAUSE_WAIT_NONE;
                endcase
            end
        end
    end

endmodule

// File: src/perf_pkg.sv
// ==============================
// Stall monitor types
// Station status, issue stage signals, causes, AXI4-Lite read
// ==============================
`include "perf_defs.svh"

package perf_pkg;

    // One reservation station as seen by the monitor
    typedef struct packed {
        logic                   occupied;
        logic                   issue_valid;
        logic [`PERF_TAG_W-1:0] operand_a_tag;
        logic [`PERF_TAG_W-1:0] operand_b_tag;
    } rs_status_t;

    // Handshakes between buffer, decode, rename and LSQ
    typedef struct packed {
        logic [`PERF_NUM_RS-1:0] decode_valid;
        logic [`PERF_NUM_RS-1:0] decode_ready;
        logic [`PERF_NUM_RS-1:0] rename_ready;
        logic [`PERF_NUM_RS-1:0] lsq_alloc_ready;
    } issue_stage_t;

    // Cause codes double as counter index within a station
    typedef enum logic [`PERF_CAUSE_W-1:0] {
        CAUSE_ISSUED       = 4'd0,
        CAUSE_MISPRED      = 4'd1,
        CAUSE_LSQ_FULL     = 4'd2,
        CAUSE_ROB_FULL     = 4'd3,
        CAUSE_DECODE_OTHER = 4'd4,
        CAUSE_BUFFER_EMPTY = 4'd5,
        CAUSE_PREV_OTHER   = 4'd6,
        CAUSE_WAIT_BOTH    = 4'd7,
        CAUSE_WAIT_A       = 4'd8,
        CAUSE_WAIT_B       = 4'd9,
        CAUSE_WAIT_NONE    = 4'd10
    } stall_cause_e;

    // AXI4-Lite read address channel
    typedef struct packed {
        logic                        arvalid;
        logic [`PERF_AXI_ADDR_W-1:0] araddr;
    } axil_ar_t;

    // AXI4-Lite read data channel
    typedef struct packed {
        logic                        rvalid;
        logic [`PERF_AXI_DATA_W-1:0] rdata;
        logic [1:0]                  rresp;
    } axil_r_t;

endpackage

// File: src/perf_defs.svh
// ==============================
// Stall monitor widths, sizes and address map
// ==============================
`ifndef PERF_DEFS_SVH
`define PERF_DEFS_SVH

// Issue stage shape
`define PERF_NUM_RS       3
`define PERF_TAG_W        3
`define PERF_TAG_READY    {`PERF_TAG_W{1'b1}}
`define PERF_ALIGN_DEPTH  2

// Counters
`define PERF_CNT_W        32
`define PERF_CAUSE_W      4
`define PERF_NUM_CAUSE    11

// AXI4-Lite read port
`define PERF_AXI_ADDR_W   32
`define PERF_AXI_DATA_W   32
`define PERF_RS_SEL_W     2
`define PERF_CAUSE_LSB    2
`define PERF_RS_LSB       6
`define PERF_RESP_OKAY    2'b00
`define PERF_RESP_SLVERR  2'b10

`endif
